// ==== logic/memory_unit_pkg.sv ====
// Bus widths and types, I/O register addresses, SPI rates and GPIO layout
package memory_unit_pkg;

    // ----------------------------------------
    // Widths and types
    // ----------------------------------------
    localparam int BUS_ADDR_W = 27;
    localparam int BUS_DATA_W = 32;
    localparam int SPI_BYTE_W = 8;
    localparam int GPIO_W     = 4;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // ----------------------------------------
    // I/O register map
    // ----------------------------------------
    // SPI1 talks to the CH376T, SPI3 to the W5500
    localparam bus_addr_t ADDR_SPI1_DATA = 27'hC0272B;
    localparam bus_addr_t ADDR_SPI1_CS   = 27'hC0272C;
    localparam bus_addr_t ADDR_SPI1_NINT = 27'hC0272D;
    localparam bus_addr_t ADDR_SPI3_DATA = 27'hC02731;
    localparam bus_addr_t ADDR_SPI3_CS   = 27'hC02732;
    localparam bus_addr_t ADDR_SPI3_INT  = 27'hC02733;
    localparam bus_addr_t ADDR_GPIO      = 27'hC02737;

    // Timers are write-only
    localparam bus_addr_t ADDR_OST1_SET  = 27'hC02739;
    localparam bus_addr_t ADDR_OST1_TRIG = 27'hC0273A;
    localparam bus_addr_t ADDR_OST2_SET  = 27'hC0273B;
    localparam bus_addr_t ADDR_OST2_TRIG = 27'hC0273C;

    localparam bus_addr_t ADDR_BOOT_MODE = 27'hC02741;

    // ----------------------------------------
    // Peripheral constants
    // ----------------------------------------
    // GPO sits above GPI in the GPIO word
    localparam int GPO_LSB = 4;

    // Clocks per SPI half bit
    localparam int SPI1_HALF_BIT = 2;
    localparam int SPI3_HALF_BIT = 1;

endpackage

// ==== logic/spi_byte_master.sv ====
// SPI mode-0 byte master, MSB first, with a configurable half-bit period
`timescale 1ns/100ps

module spi_byte_master
    import memory_unit_pkg::*;
#(
    parameter int CLKS_PER_HALF_BIT = 2
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_start,
    input  logic [SPI_BYTE_W-1:0] i_tx_byte,
    output logic                  o_done,
    output logic [SPI_BYTE_W-1:0] o_rx_byte,
    output logic                  o_spi_clk,
    output logic                  o_spi_mosi,
    input  logic                  i_spi_miso
);

    localparam int HALF_W = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;
    localparam int BIT_W  = $clog2(SPI_BYTE_W);

    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(CLKS_PER_HALF_BIT - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(SPI_BYTE_W - 1);

    logic                  busy;
    logic [HALF_W-1:0]     half_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [SPI_BYTE_W-1:0] tx_shift;
    logic [SPI_BYTE_W-1:0] rx_shift;
    logic                  half_end;
    logic                  rise;
    logic                  fall;

    // SPI clock toggles at the end of each half bit
    assign half_end = busy && (half_cnt == HALF_LAST);
    assign rise     = half_end && !o_spi_clk;
    assign fall     = half_end && o_spi_clk;

    // First bit is on the line before the first rising edge
    assign o_spi_mosi = busy & tx_shift[SPI_BYTE_W-1];

    // ----------------------------------------
    // Half-bit and bit counters
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            o_spi_clk <= 1'b0;
            o_done    <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (!busy)
            begin
                if (i_start)
                begin
                    busy     <= 1'b1;
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end
            else if (half_end)
            begin
                half_cnt  <= '0;
                o_spi_clk <= ~o_spi_clk;
                // Byte ends on the eighth falling edge
                if (fall)
                begin
                    if (bit_cnt == BIT_LAST)
                    begin
                        busy   <= 1'b0;
                        o_done <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Shift registers
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (!busy && i_start)
        begin
            tx_shift <= i_tx_byte;
        end
        else if (fall)
        begin
            tx_shift <= {tx_shift[SPI_BYTE_W-2:0], 1'b0};
        end

        // Sample MISO as the clock rises
        if (rise)
        begin
            rx_shift <= {rx_shift[SPI_BYTE_W-2:0], i_spi_miso};
        end

        if (fall && (bit_cnt == BIT_LAST))
        begin
            o_rx_byte <= rx_shift;
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset) busy |-> !i_start
    ) else $error("SPI start while a transfer is in progress");

endmodule

// ==== logic/os_timer.sv ====
// One-shot countdown timer with reload register and interrupt pulse
`timescale 1ns/100ps

module os_timer
#(
    parameter int TIMER_W = 32
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic [TIMER_W-1:0] i_value,
    input  logic               i_set,
    input  logic               i_trigger,
    output logic               o_interrupt
);

    logic [TIMER_W-1:0] reload;
    logic [TIMER_W-1:0] count;
    logic               running;
    logic               last_tick;

    // Counter holds 1 on the edge before it reaches zero
    assign last_tick = running && (count == TIMER_W'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload      <= '0;
            running     <= 1'b0;
            o_interrupt <= 1'b0;
        end
        else
        begin
            o_interrupt <= last_tick && !i_trigger;
            if (i_set)
            begin
                reload <= i_value;
            end
            // A new trigger restarts the count, a zero reload never fires
            if (i_trigger)
            begin
                running <= (reload != '0);
            end
            else if (last_tick)
            begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_trigger)
        begin
            count <= reload;
        end
        else if (running)
        begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== logic/io_register_bank.sv ====
// I/O bus decoder and access sequencer with CS, GPO and read-data registers
`timescale 1ns/100ps

module io_register_bank
    import memory_unit_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  bus_addr_t             i_bus_addr,
    input  bus_data_t             i_bus_data,
    input  logic                  i_bus_we,
    input  logic                  i_bus_start,
    output bus_data_t             o_bus_q,
    output logic                  o_bus_done,
    input  logic                  i_spi1_done,
    input  logic [SPI_BYTE_W-1:0] i_spi1_rx,
    input  logic                  i_spi3_done,
    input  logic [SPI_BYTE_W-1:0] i_spi3_rx,
    input  logic                  i_spi1_nint,
    input  logic                  i_spi3_int,
    input  logic [GPIO_W-1:0]     i_gpi,
    input  logic                  i_boot_mode,
    output logic                  o_spi1_start,
    output logic [SPI_BYTE_W-1:0] o_spi1_tx,
    output logic                  o_spi3_start,
    output logic [SPI_BYTE_W-1:0] o_spi3_tx,
    output logic                  o_spi1_cs,
    output logic                  o_spi3_cs,
    output logic [GPIO_W-1:0]     o_gpo,
    output logic                  o_ost1_set,
    output logic                  o_ost1_trig,
    output logic                  o_ost2_set,
    output logic                  o_ost2_trig,
    output bus_data_t             o_timer_value
);

    typedef enum logic [1:0] {ST_IDLE, ST_REG_WAIT, ST_SPI_WAIT} state_t;

    state_t                state;
    logic                  bus_armed;
    logic                  reg_delay;
    logic                  spi_sel;
    logic                  accept;
    logic                  spi_done;
    logic [SPI_BYTE_W-1:0] spi_rx;
    bus_data_t             reg_mux;
    bus_data_t             reg_rdata;

    // Start must drop after done before the next access is taken
    assign accept = i_bus_start && bus_armed && (state == ST_IDLE);

    // ----------------------------------------
    // Single-cycle pulses at acceptance
    // ----------------------------------------
    assign o_spi1_start = accept && (i_bus_addr == ADDR_SPI1_DATA);
    assign o_spi3_start = accept && (i_bus_addr == ADDR_SPI3_DATA);
    assign o_spi1_tx    = i_bus_data[SPI_BYTE_W-1:0];
    assign o_spi3_tx    = i_bus_data[SPI_BYTE_W-1:0];

    assign o_ost1_set    = accept && i_bus_we && (i_bus_addr == ADDR_OST1_SET);
    assign o_ost1_trig   = accept && i_bus_we && (i_bus_addr == ADDR_OST1_TRIG);
    assign o_ost2_set    = accept && i_bus_we && (i_bus_addr == ADDR_OST2_SET);
    assign o_ost2_trig   = accept && i_bus_we && (i_bus_addr == ADDR_OST2_TRIG);
    assign o_timer_value = i_bus_data;

    // Port that owns the open SPI wait
    assign spi_done = spi_sel ? i_spi3_done : i_spi1_done;
    assign spi_rx   = spi_sel ? i_spi3_rx : i_spi1_rx;

    // Register read values, unmapped and write-only read as zero
    always_comb
    begin
        reg_mux = '0;
        case (i_bus_addr)
            ADDR_SPI1_CS:   reg_mux[0] = o_spi1_cs;
            ADDR_SPI1_NINT: reg_mux[0] = i_spi1_nint;
            ADDR_SPI3_CS:   reg_mux[0] = o_spi3_cs;
            ADDR_SPI3_INT:  reg_mux[0] = i_spi3_int;
            ADDR_GPIO:
            begin
                reg_mux[GPO_LSB +: GPIO_W] = o_gpo;
                reg_mux[GPIO_W-1:0]        = i_gpi;
            end
            ADDR_BOOT_MODE: reg_mux[0] = i_boot_mode;
            default:        reg_mux = '0;
        endcase
    end

    // ----------------------------------------
    // Access sequencer and control registers
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            bus_armed  <= 1'b1;
            reg_delay  <= 1'b0;
            spi_sel    <= 1'b0;
            o_bus_done <= 1'b0;
            o_spi1_cs  <= 1'b1;
            o_spi3_cs  <= 1'b1;
            o_gpo      <= '0;
        end
        else
        begin
            o_bus_done <= 1'b0;

            if (accept)
            begin
                bus_armed <= 1'b0;
            end
            else if (!i_bus_start)
            begin
                bus_armed <= 1'b1;
            end

            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        reg_delay <= 1'b0;
                        spi_sel   <= (i_bus_addr == ADDR_SPI3_DATA);
                        if (o_spi1_start || o_spi3_start)
                        begin
                            state <= ST_SPI_WAIT;
                        end
                        else
                        begin
                            state <= ST_REG_WAIT;
                        end
                    end
                end
                // Done two cycles after acceptance
                ST_REG_WAIT:
                begin
                    reg_delay <= 1'b1;
                    if (reg_delay)
                    begin
                        o_bus_done <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                ST_SPI_WAIT:
                begin
                    if (spi_done)
                    begin
                        o_bus_done <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            // Register writes land at acceptance
            if (accept && i_bus_we)
            begin
                case (i_bus_addr)
                    ADDR_SPI1_CS: o_spi1_cs <= i_bus_data[0];
                    ADDR_SPI3_CS: o_spi3_cs <= i_bus_data[0];
                    ADDR_GPIO:    o_gpo     <= i_bus_data[GPO_LSB +: GPIO_W];
                    default:      ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Read data
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            reg_rdata <= reg_mux;
        end

        // Bus data changes only when an access completes
        if ((state == ST_REG_WAIT) && reg_delay)
        begin
            o_bus_q <= reg_rdata;
        end
        else if ((state == ST_SPI_WAIT) && spi_done)
        begin
            o_bus_q <= {{(BUS_DATA_W-SPI_BYTE_W){1'b0}}, spi_rx};
        end
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (reset) o_bus_done |=> !o_bus_done
    ) else $error("Bus done held for two cycles");

    // An SPI wait runs from its start pulse to the bus done that closes it
    a_no_spi_overlap: assert property (
        @(posedge clk) disable iff (reset)
        (o_spi1_start || o_spi3_start) |=>
            (!(o_spi1_start || o_spi3_start) throughout o_bus_done[->1])
    ) else $error("SPI start issued while an SPI access is open");

endmodule

// ==== logic/memory_unit_top.sv ====
// Memory unit I/O top level with register bank, two SPI ports and two timers
`timescale 1ns/100ps

module memory_unit_top
    import memory_unit_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // CPU bus
    input  bus_addr_t         i_bus_addr,
    input  bus_data_t         i_bus_data,
    input  logic              i_bus_we,
    input  logic              i_bus_start,
    output bus_data_t         o_bus_q,
    output logic              o_bus_done,

    // SPI1 to CH376T
    output logic              o_spi1_clk,
    output logic              o_spi1_mosi,
    output logic              o_spi1_cs,
    input  logic              i_spi1_miso,
    input  logic              i_spi1_nint,

    // SPI3 to W5500
    output logic              o_spi3_clk,
    output logic              o_spi3_mosi,
    output logic              o_spi3_cs,
    input  logic              i_spi3_miso,
    input  logic              i_spi3_int,

    input  logic [GPIO_W-1:0] i_gpi,
    output logic [GPIO_W-1:0] o_gpo,
    output logic              o_ost1_int,
    output logic              o_ost2_int,
    input  logic              i_boot_mode
);

    logic                  spi1_start;
    logic                  spi1_done;
    logic [SPI_BYTE_W-1:0] spi1_tx;
    logic [SPI_BYTE_W-1:0] spi1_rx;
    logic                  spi3_start;
    logic                  spi3_done;
    logic [SPI_BYTE_W-1:0] spi3_tx;
    logic [SPI_BYTE_W-1:0] spi3_rx;
    logic                  ost1_set;
    logic                  ost1_trig;
    logic                  ost2_set;
    logic                  ost2_trig;
    bus_data_t             timer_value;

    // ----------------------------------------
    // Register bank
    // ----------------------------------------
    io_register_bank u_bank (
        .clk           (clk),
        .reset         (reset),
        .i_bus_addr    (i_bus_addr),
        .i_bus_data    (i_bus_data),
        .i_bus_we      (i_bus_we),
        .i_bus_start   (i_bus_start),
        .o_bus_q       (o_bus_q),
        .o_bus_done    (o_bus_done),
        .i_spi1_done   (spi1_done),
        .i_spi1_rx     (spi1_rx),
        .i_spi3_done   (spi3_done),
        .i_spi3_rx     (spi3_rx),
        .i_spi1_nint   (i_spi1_nint),
        .i_spi3_int    (i_spi3_int),
        .i_gpi         (i_gpi),
        .i_boot_mode   (i_boot_mode),
        .o_spi1_start  (spi1_start),
        .o_spi1_tx     (spi1_tx),
        .o_spi3_start  (spi3_start),
        .o_spi3_tx     (spi3_tx),
        .o_spi1_cs     (o_spi1_cs),
        .o_spi3_cs     (o_spi3_cs),
        .o_gpo         (o_gpo),
        .o_ost1_set    (ost1_set),
        .o_ost1_trig   (ost1_trig),
        .o_ost2_set    (ost2_set),
        .o_ost2_trig   (ost2_trig),
        .o_timer_value (timer_value)
    );

    // ----------------------------------------
    // SPI ports
    // ----------------------------------------
    // CH376T runs at half the W5500 bit rate
    spi_byte_master #(.CLKS_PER_HALF_BIT(SPI1_HALF_BIT)) u_spi1 (
        .clk        (clk),
        .reset      (reset),
        .i_start    (spi1_start),
        .i_tx_byte  (spi1_tx),
        .o_done     (spi1_done),
        .o_rx_byte  (spi1_rx),
        .o_spi_clk  (o_spi1_clk),
        .o_spi_mosi (o_spi1_mosi),
        .i_spi_miso (i_spi1_miso)
    );

    spi_byte_master #(.CLKS_PER_HALF_BIT(SPI3_HALF_BIT)) u_spi3 (
        .clk        (clk),
        .reset      (reset),
        .i_start    (spi3_start),
        .i_tx_byte  (spi3_tx),
        .o_done     (spi3_done),
        .o_rx_byte  (spi3_rx),
        .o_spi_clk  (o_spi3_clk),
        .o_spi_mosi (o_spi3_mosi),
        .i_spi_miso (i_spi3_miso)
    );

    // ----------------------------------------
    // OS timers
    // ----------------------------------------
    os_timer #(.TIMER_W(BUS_DATA_W)) u_ost1 (
        .clk         (clk),
        .reset       (reset),
        .i_value     (timer_value),
        .i_set       (ost1_set),
        .i_trigger   (ost1_trig),
        .o_interrupt (o_ost1_int)
    );

    os_timer #(.TIMER_W(BUS_DATA_W)) u_ost2 (
        .clk         (clk),
        .reset       (reset),
        .i_value     (timer_value),
        .i_set       (ost2_set),
        .i_trigger   (ost2_trig),
        .o_interrupt (o_ost2_int)
    );

endmodule

// ==== dv/memory_unit_tb.sv ====
// Memory unit I/O testbench with SPI slave models, reference model, checks and timeout
`timescale 1ns/100ps

// SPI mode-0 slave that shifts a byte out MSB first and captures MOSI
module spi_slave_model
(
    input  logic       i_reset,
    input  logic       i_sclk,
    input  logic       i_mosi,
    output logic       o_miso,
    input  logic [7:0] i_tx_byte,
    output logic [7:0] o_rx_byte
);

    logic [2:0] bit_idx = 3'd0;

    assign o_miso = i_tx_byte[3'd7 - bit_idx];

    // Next bit goes out on the falling edge, wraps after eight
    always @(negedge i_sclk)
    begin
        if (!i_reset)
        begin
            bit_idx <= bit_idx + 3'd1;
        end
    end

    always @(posedge i_sclk)
    begin
        o_rx_byte <= {o_rx_byte[6:0], i_mosi};
    end

endmodule

module memory_unit_tb
    import memory_unit_pkg::*;
();

    localparam int CS_ROUNDS     = 30;
    localparam int SPI_BYTES     = 20;
    localparam int STATUS_ROUNDS = 8;
    localparam int TIMER_ROUNDS  = 2;
    localparam int TIMER_WAIT    = 64 + 6;
    localparam int REG_LATENCY   = 2;
    localparam int ACCESS_COUNT  = 2 + 4 * CS_ROUNDS + 2 * (SPI_BYTES + 2)
                                   + 5 * STATUS_ROUNDS + 4 * TIMER_ROUNDS;
    // Slowest port plus start, idle gap and done delay
    localparam int WORST_ACCESS  = 16 * SPI1_HALF_BIT + 8;
    localparam int TIMEOUT_CYCLES = 2 * (ACCESS_COUNT * WORST_ACCESS
                                    + 2 * TIMER_ROUNDS * TIMER_WAIT) + 100;

    logic              clk = 1'b0;
    logic              reset;
    bus_addr_t         bus_addr;
    bus_data_t         bus_data;
    logic              bus_we;
    logic              bus_start;
    bus_data_t         bus_q;
    logic              bus_done;
    logic              spi1_clk, spi1_mosi, spi1_cs, spi1_miso, spi1_nint;
    logic              spi3_clk, spi3_mosi, spi3_cs, spi3_miso, spi3_int;
    logic [GPIO_W-1:0] gpi;
    logic [GPIO_W-1:0] gpo;
    logic              ost1_int, ost2_int;
    logic              boot_mode;
    logic [7:0]        spi1_slave_tx, spi1_slave_rx;
    logic [7:0]        spi3_slave_tx, spi3_slave_rx;

    // Reference model
    logic              model_spi1_cs;
    logic              model_spi3_cs;
    logic [GPIO_W-1:0] model_gpo;
    bus_data_t         model_timer[2];

    logic [15:0] lfsr_state  = 16'd73;
    int          cycle_count = 0;
    int          pulse_count[2] = '{0, 0};
    int          pulse_cycle[2] = '{0, 0};

    always #5 clk = ~clk;

    memory_unit_top uut (
        .clk (clk), .reset (reset),
        .i_bus_addr (bus_addr), .i_bus_data (bus_data), .i_bus_we (bus_we),
        .i_bus_start (bus_start), .o_bus_q (bus_q), .o_bus_done (bus_done),
        .o_spi1_clk (spi1_clk), .o_spi1_mosi (spi1_mosi), .o_spi1_cs (spi1_cs),
        .i_spi1_miso (spi1_miso), .i_spi1_nint (spi1_nint),
        .o_spi3_clk (spi3_clk), .o_spi3_mosi (spi3_mosi), .o_spi3_cs (spi3_cs),
        .i_spi3_miso (spi3_miso), .i_spi3_int (spi3_int),
        .i_gpi (gpi), .o_gpo (gpo), .o_ost1_int (ost1_int), .o_ost2_int (ost2_int),
        .i_boot_mode (boot_mode)
    );

    spi_slave_model u_slave1 (
        .i_reset (reset), .i_sclk (spi1_clk), .i_mosi (spi1_mosi), .o_miso (spi1_miso),
        .i_tx_byte (spi1_slave_tx), .o_rx_byte (spi1_slave_rx)
    );

    spi_slave_model u_slave3 (
        .i_reset (reset), .i_sclk (spi3_clk), .i_mosi (spi3_mosi), .o_miso (spi3_miso),
        .i_tx_byte (spi3_slave_tx), .o_rx_byte (spi3_slave_rx)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Testbench stopped at the first error");
    endtask

    task automatic check_equal(input bus_data_t actual, input bus_data_t expected,
                               input string msg);
        if (actual !== expected)
        begin
            abort_run($sformatf("mismatch at %0t: %s, got %h expected %h",
                                $time, msg, actual, expected));
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic bus_data_t rand_bits(input int n);
        bus_data_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[BUS_DATA_W-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bus_data_t gpio_word();
        return (bus_data_t'(model_gpo) << GPO_LSB) | bus_data_t'(gpi);
    endfunction

    // Runs of the clock and timer watch
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    // Interrupts sampled mid-cycle
    always @(negedge clk)
    begin
        if (ost1_int)
        begin
            pulse_count[0] = pulse_count[0] + 1;
            pulse_cycle[0] = cycle_count;
        end
        if (ost2_int)
        begin
            pulse_count[1] = pulse_count[1] + 1;
            pulse_cycle[1] = cycle_count;
        end
    end

    // ----------------------------------------
    // Bus access tasks
    // ----------------------------------------
    task automatic bus_access(input bus_addr_t addr, input bus_data_t data, input logic we,
                              output bus_data_t q, output int accept_cycle,
                              output int latency);
        @(posedge clk);
        #1;
        bus_addr  = addr;
        bus_data  = data;
        bus_we    = we;
        bus_start = 1'b1;
        // Bank is idle, so the next edge accepts
        @(posedge clk);
        #1;
        accept_cycle = cycle_count;
        while (!bus_done)
        begin
            @(posedge clk);
            #1;
        end
        latency   = cycle_count - accept_cycle;
        q         = bus_q;
        bus_start = 1'b0;
    endtask

    task automatic reg_access(input bus_addr_t addr, input bus_data_t data, input logic we,
                              output bus_data_t q);
        int accept_cycle;
        int latency;
        bus_access(addr, data, we, q, accept_cycle, latency);
        check_equal(latency, REG_LATENCY, "register access done latency");
    endtask

    task automatic reg_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t q;
        reg_access(addr, data, 1'b1, q);
    endtask

    task automatic reg_read_check(input bus_addr_t addr, input bus_data_t expected,
                                  input string msg);
        bus_data_t q;
        reg_access(addr, '0, 1'b0, q);
        check_equal(q, expected, msg);
    endtask

    task automatic check_pins();
        check_equal(spi1_cs, model_spi1_cs, "SPI1 chip select pin");
        check_equal(spi3_cs, model_spi3_cs, "SPI3 chip select pin");
        check_equal(gpo, model_gpo, "GPO pins");
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        check_pins();
        check_equal(spi1_clk, 1'b0, "SPI1 clock after reset");
        check_equal(spi3_clk, 1'b0, "SPI3 clock after reset");
        check_equal(ost1_int, 1'b0, "timer 1 interrupt after reset");
        check_equal(ost2_int, 1'b0, "timer 2 interrupt after reset");
        reg_read_check(ADDR_BOOT_MODE, bus_data_t'(boot_mode), "boot mode read");
        // Both boot mode levels
        boot_mode = ~boot_mode;
        reg_read_check(ADDR_BOOT_MODE, bus_data_t'(boot_mode), "boot mode read");
    endtask

    task automatic test_control_regs();
        bus_data_t data;
        int        sel;
        for (int i = 0; i < CS_ROUNDS; i++)
        begin
            sel  = int'(rand_bits(2)) % 3;
            data = rand_bits(32);
            case (sel)
                0:
                begin
                    reg_write(ADDR_SPI1_CS, data);
                    model_spi1_cs = data[0];
                end
                1:
                begin
                    reg_write(ADDR_SPI3_CS, data);
                    model_spi3_cs = data[0];
                end
                default:
                begin
                    reg_write(ADDR_GPIO, data);
                    model_gpo = data[GPO_LSB +: GPIO_W];
                end
            endcase
            check_pins();
            reg_read_check(ADDR_SPI1_CS, bus_data_t'(model_spi1_cs), "SPI1 CS read");
            reg_read_check(ADDR_SPI3_CS, bus_data_t'(model_spi3_cs), "SPI3 CS read");
            reg_read_check(ADDR_GPIO, gpio_word(), "GPIO read");
        end
    endtask

    task automatic test_spi_port(input int port);
        bus_addr_t  data_addr;
        bus_addr_t  cs_addr;
        bus_data_t  q;
        bus_data_t  tx;
        logic [7:0] slave_byte;
        logic [7:0] captured;
        logic       we;
        int         half_bit;
        int         accept_cycle;
        int         latency;
        data_addr = (port == 1) ? ADDR_SPI1_DATA : ADDR_SPI3_DATA;
        cs_addr   = (port == 1) ? ADDR_SPI1_CS : ADDR_SPI3_CS;
        half_bit  = (port == 1) ? SPI1_HALF_BIT : SPI3_HALF_BIT;
        reg_write(cs_addr, '0);
        if (port == 1) model_spi1_cs = 1'b0;
        else model_spi3_cs = 1'b0;
        for (int i = 0; i < SPI_BYTES; i++)
        begin
            tx         = rand_bits(32);
            slave_byte = 8'(rand_bits(8));
            we         = (rand_bits(1) != 0);
            if (port == 1) spi1_slave_tx = slave_byte;
            else spi3_slave_tx = slave_byte;
            bus_access(data_addr, tx, we, q, accept_cycle, latency);
            captured = (port == 1) ? spi1_slave_rx : spi3_slave_rx;
            check_equal(captured, tx[7:0], "byte seen by SPI slave");
            check_equal(q, bus_data_t'(slave_byte), "SPI read data");
            check_equal(latency >= 16 * half_bit, 1'b1, "SPI access shorter than a byte");
        end
        reg_write(cs_addr, 32'd1);
        if (port == 1) model_spi1_cs = 1'b1;
        else model_spi3_cs = 1'b1;
        check_pins();
    endtask

    task automatic test_status_regs();
        bus_addr_t addr;
        for (int i = 0; i < STATUS_ROUNDS; i++)
        begin
            gpi       = GPIO_W'(rand_bits(GPIO_W));
            spi1_nint = (rand_bits(1) != 0);
            spi3_int  = (rand_bits(1) != 0);
            reg_read_check(ADDR_SPI1_NINT, bus_data_t'(spi1_nint), "SPI1 interrupt status");
            reg_read_check(ADDR_SPI3_INT, bus_data_t'(spi3_int), "SPI3 interrupt status");
            reg_read_check(ADDR_GPIO, gpio_word(), "GPI read");
            // Somewhere past the last mapped register
            addr = bus_addr_t'(ADDR_BOOT_MODE + 1 + rand_bits(20));
            reg_write(addr, rand_bits(32));
            reg_read_check(addr, '0, "unmapped address read");
            check_pins();
        end
    endtask

    task automatic test_timer(input int idx);
        bus_addr_t set_addr;
        bus_addr_t trig_addr;
        bus_data_t q;
        int        accept_cycle;
        int        latency;
        set_addr  = (idx == 0) ? ADDR_OST1_SET : ADDR_OST2_SET;
        trig_addr = (idx == 0) ? ADDR_OST1_TRIG : ADDR_OST2_TRIG;
        model_timer[idx] = 1 + rand_bits(6);
        reg_write(set_addr, model_timer[idx]);
        pulse_count[0] = 0;
        pulse_count[1] = 0;
        bus_access(trig_addr, rand_bits(32), 1'b1, q, accept_cycle, latency);
        check_equal(latency, REG_LATENCY, "timer trigger done latency");
        repeat (TIMER_WAIT) @(posedge clk);
        #1;
        check_equal(pulse_count[idx], 1, "timer interrupt pulse count");
        check_equal(pulse_cycle[idx] - accept_cycle, model_timer[idx], "timer interrupt delay");
        check_equal(pulse_count[1 - idx], 0, "untriggered timer interrupt");
    endtask

    initial
    begin
        reset         = 1'b1;
        bus_addr      = '0;
        bus_data      = '0;
        bus_we        = 1'b0;
        bus_start     = 1'b0;
        spi1_nint     = 1'b1;
        spi3_int      = 1'b0;
        gpi           = '0;
        spi1_slave_tx = '0;
        spi3_slave_tx = '0;
        boot_mode     = (rand_bits(1) != 0);
        model_spi1_cs = 1'b1;
        model_spi3_cs = 1'b1;
        model_gpo     = '0;
        model_timer   = '{'0, '0};
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_control_regs();
        test_spi_port(1);
        test_spi_port(3);
        test_status_regs();
        for (int r = 0; r < TIMER_ROUNDS; r++)
        begin
            test_timer(0);
            test_timer(1);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/memory_unit_pkg.sv
logic/spi_byte_master.sv
logic/os_timer.sv
logic/io_register_bank.sv
logic/memory_unit_top.sv
dv/memory_unit_tb.sv

// ==== Bender.yml ====
package:
  name: memory_unit

sources:
  - logic/memory_unit_pkg.sv
  - logic/spi_byte_master.sv
  - logic/os_timer.sv
  - logic/io_register_bank.sv
  - logic/memory_unit_top.sv
  - target: test
    files:
      - dv/memory_unit_tb.sv
